/* regstate_top.f */
+incdir+src
src/regstate_pkg.sv
src/gpr_if.sv
src/csr_if.sv
src/gpr_file.sv
src/csr_file.sv
src/commit_unit.sv
src/regstate_top.sv
verif/regstate_checker.sv
verif/regstate_tb.sv

/* Makefile */
SIM  := obj_dir/Vregstate_tb
SRCS := $(wildcard src/*.sv src/*.svh verif/*.sv)

.PHONY: all run clean

all: run

$(SIM): regstate_top.f $(SRCS)
	verilator --binary --timing --assert --top-module regstate_tb -f regstate_top.f

run: $(SIM)
	./$(SIM) +verilator+error+limit+100 | tee sim.log
	grep -qF '*** PASSED ***' sim.log

clean:
	rm -rf obj_dir sim.log

/* verif/regstate_tb.sv */
`timescale 1ns/1ps
`include "core_cfg.svh"

module regstate_tb;

    import regstate_pkg::*;

    logic                   clk;
    logic                   rst_n;
    logic                   commit_valid;
    commit_op_e             commit_op;
    logic [`GPR_ADDR_W-1:0] commit_rd;
    logic [`GPR_ADDR_W-1:0] commit_rs1;
    logic [`CSR_ADDR_W-1:0] commit_csr;
    logic [`XLEN-1:0]       commit_pc;
    logic [`XLEN-1:0]       commit_result;
    logic [`GPR_ADDR_W-1:0] dbg_gpr_addr;
    logic [`XLEN-1:0]       dbg_gpr_data;
    logic [`XLEN-1:0]       mstatus;
    logic [`XLEN-1:0]       mtvec;
    logic [`XLEN-1:0]       mepc;
    logic [`XLEN-1:0]       mcause;
    logic                   redirect_valid;
    logic [`XLEN-1:0]       redirect_pc;

    // Reference state
    logic [`XLEN-1:0] m_gpr [`GPR_COUNT];
    logic [`XLEN-1:0] m_mstatus;
    logic [`XLEN-1:0] m_mtvec;
    logic [`XLEN-1:0] m_mepc;
    logic [`XLEN-1:0] m_mcause;
    logic             m_redir_valid;
    logic [`XLEN-1:0] m_redir_pc;

    logic [31:0] lcg_state;
    string       cur_test;
    int          checks;
    int          errors;

    regstate_top i_dut (
        .clk            (clk),
        .rst_n          (rst_n),
        .commit_valid   (commit_valid),
        .commit_op      (commit_op),
        .commit_rd      (commit_rd),
        .commit_rs1     (commit_rs1),
        .commit_csr     (commit_csr),
        .commit_pc      (commit_pc),
        .commit_result  (commit_result),
        .dbg_gpr_addr   (dbg_gpr_addr),
        .dbg_gpr_data   (dbg_gpr_data),
        .mstatus        (mstatus),
        .mtvec          (mtvec),
        .mepc           (mepc),
        .mcause         (mcause),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

    always #10 clk = ~clk;

    function automatic logic [15:0] rand16();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[31:16];
    endfunction

    function automatic logic [`XLEN-1:0] rand32();
        return {rand16(), rand16()};
    endfunction

    function automatic commit_op_e pick_op();
        logic [15:0] r;
        r = rand16();
        case (r[3:0])
            4'd6, 4'd7, 4'd8:   return OP_CSRRW;
            4'd9, 4'd10, 4'd11: return OP_CSRRS;
            4'd12:              return OP_ECALL;
            4'd13:              return OP_MRET;
            4'd14:              return OP_NONE;
            default:            return OP_REG;
        endcase
    endfunction

    // 0xFxx never hits an implemented CSR
    function automatic logic [`CSR_ADDR_W-1:0] pick_csr();
        logic [15:0] r;
        r = rand16();
        case (r[2:0])
            3'd0:       return CSR_MSTATUS;
            3'd1, 3'd5: return CSR_MTVEC;
            3'd2, 3'd6: return CSR_MEPC;
            3'd3:       return CSR_MCAUSE;
            default:    return {4'hf, r[15:8]};
        endcase
    endfunction

    function automatic logic [`XLEN-1:0] csr_model_read(input logic [`CSR_ADDR_W-1:0] addr);
        case (addr)
            CSR_MSTATUS: return m_mstatus;
            CSR_MTVEC:   return m_mtvec;
            CSR_MEPC:    return m_mepc;
            CSR_MCAUSE:  return m_mcause;
            default:     return '0;
        endcase
    endfunction

    task automatic csr_model_write(input logic [`CSR_ADDR_W-1:0] addr,
                                   input logic [`XLEN-1:0] data);
        case (addr)
            CSR_MSTATUS: m_mstatus = data;
            CSR_MTVEC:   m_mtvec = data;
            CSR_MEPC:    m_mepc = data;
            CSR_MCAUSE:  m_mcause = data;
            default:     ;
        endcase
    endtask

    task automatic check_value(input string name, input logic [`XLEN-1:0] expected,
                               input logic [`XLEN-1:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Mismatch %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    // Outputs settle after the rising edge, sampled at the falling one
    task automatic check_state();
        check_value({cur_test, " gpr"}, m_gpr[dbg_gpr_addr], dbg_gpr_data);
        check_value({cur_test, " mstatus"}, m_mstatus, mstatus);
        check_value({cur_test, " mtvec"}, m_mtvec, mtvec);
        check_value({cur_test, " mepc"}, m_mepc, mepc);
        check_value({cur_test, " mcause"}, m_mcause, mcause);
        check_value({cur_test, " redirect_valid"}, `XLEN'(m_redir_valid),
                    `XLEN'(redirect_valid));
        if (m_redir_valid) begin
            check_value({cur_test, " redirect_pc"}, m_redir_pc, redirect_pc);
        end
    endtask

    task automatic idle(input logic [`GPR_ADDR_W-1:0] addr);
        @(negedge clk);
        check_state();
        commit_valid = 1'b0;
        commit_op = pick_op();
        dbg_gpr_addr = addr;
        m_redir_valid = 1'b0;
        cur_test = "idle";
    endtask

    task automatic retire(input commit_op_e op, input logic [`GPR_ADDR_W-1:0] rd,
                          input logic [`GPR_ADDR_W-1:0] rs1,
                          input logic [`CSR_ADDR_W-1:0] csr,
                          input logic [`XLEN-1:0] pc, input logic [`XLEN-1:0] result);
        logic [`XLEN-1:0] old_csr;
        logic [`XLEN-1:0] rs1_val;
        @(negedge clk);
        check_state();
        commit_valid = 1'b1;
        commit_op = op;
        commit_rd = rd;
        commit_rs1 = rs1;
        commit_csr = csr;
        commit_pc = pc;
        commit_result = result;
        dbg_gpr_addr = rd;
        cur_test = op.name();
        old_csr = csr_model_read(csr);
        rs1_val = m_gpr[rs1];
        m_redir_valid = 1'b0;
        case (op)
            OP_REG: begin
                if (rd != '0) m_gpr[rd] = result;
            end
            OP_CSRRW, OP_CSRRS: begin
                csr_model_write(csr, (op == OP_CSRRS) ? (old_csr | rs1_val) : rs1_val);
                if (rd != '0) m_gpr[rd] = old_csr;
            end
            OP_ECALL: begin
                m_redir_valid = 1'b1;
                m_redir_pc = m_mtvec;
                m_mepc = pc;
                m_mcause = `XLEN'(`CAUSE_ECALL_M);
                m_mstatus[`MSTATUS_MPIE] = m_mstatus[`MSTATUS_MIE];
                m_mstatus[`MSTATUS_MIE] = 1'b0;
                m_mstatus[`MSTATUS_MPP_LO +: 2] = 2'b11;
            end
            OP_MRET: begin
                m_redir_valid = 1'b1;
                m_redir_pc = m_mepc;
                m_mstatus[`MSTATUS_MIE] = m_mstatus[`MSTATUS_MPIE];
                m_mstatus[`MSTATUS_MPIE] = 1'b1;
            end
            default: ;
        endcase
    endtask

    task automatic wait_redirect(input string name);
        logic seen;
        seen = 1'b0;
        for (int n = 0; n < 4 && !seen; n++) begin
            idle(5'd0);
            seen = redirect_valid;
        end
        if (!seen) begin
            errors++;
            $display("Timeout: no redirect seen within 4 cycles after %s", name);
        end
    endtask

    initial begin
        logic [15:0] r;
        clk = 1'b0;
        rst_n = 1'b0;
        commit_valid = 1'b0;
        commit_op = OP_NONE;
        commit_rd = '0;
        commit_rs1 = '0;
        commit_csr = '0;
        commit_pc = '0;
        commit_result = '0;
        dbg_gpr_addr = '0;
        lcg_state = 32'd41208;
        m_gpr[0] = '0;
        m_mstatus = '0;
        m_mtvec = '0;
        m_mepc = '0;
        m_mcause = '0;
        m_redir_valid = 1'b0;
        m_redir_pc = '0;
        checks = 0;
        errors = 0;
        cur_test = "reset";

        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        check_state();

        // Fill every register, x0 included
        for (int i = 0; i < `GPR_COUNT; i++) begin
            retire(OP_REG, `GPR_ADDR_W'(i), 5'd0, 12'h000, 32'h0, rand32());
        end

        retire(OP_CSRRW, 5'd1, 5'd2, CSR_MTVEC, 32'h0, 32'h0);
        retire(OP_CSRRS, 5'd3, 5'd4, CSR_MSTATUS, 32'h0, 32'h0);
        retire(OP_ECALL, 5'd0, 5'd0, 12'h000, 32'h0000_1000, 32'h0);
        wait_redirect("ECALL");
        retire(OP_MRET, 5'd0, 5'd0, 12'h000, 32'h0, 32'h0);
        wait_redirect("MRET");
        retire(OP_ECALL, 5'd0, 5'd0, 12'h000, 32'h0000_2000, 32'h0);
        retire(OP_MRET, 5'd0, 5'd0, 12'h000, 32'h0, 32'h0);
        retire(OP_CSRRS, 5'd7, 5'd8, 12'hfc0, 32'h0, 32'h0);
        retire(OP_CSRRW, 5'd9, 5'd10, 12'h7c0, 32'h0, 32'h0);

        for (int i = 0; i < 400; i++) begin
            r = rand16();
            if (r[15:14] == 2'b00) begin
                idle(r[4:0]);
            end
            r = rand16();
            retire(pick_op(), r[4:0], r[9:5], pick_csr(), rand32(), rand32());
        end

        for (int i = 0; i < `GPR_COUNT; i++) begin
            idle(`GPR_ADDR_W'(i));
        end
        @(negedge clk);
        check_state();

        errors += i_dut.u_checker.failures;
        $display("Checks: %0d, errors: %0d (assertion failures: %0d)",
                 checks, errors, i_dut.u_checker.failures);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

/* verif/regstate_checker.sv */
`timescale 1ns/1ps
`include "core_cfg.svh"

module regstate_checker (
    input logic                     clk,
    input logic                     rst_n,
    input logic                     commit_valid,
    input regstate_pkg::commit_op_e commit_op,
    input logic [`GPR_ADDR_W-1:0]   dbg_gpr_addr,
    input logic [`XLEN-1:0]         dbg_gpr_data,
    input logic                     redirect_valid
);

    import regstate_pkg::*;

    int failures = 0;
    logic is_flow;

    assign is_flow = commit_valid && ((commit_op == OP_ECALL) || (commit_op == OP_MRET));

    // Low in reset and in the first cycle out of it
    redirect_in_reset: assert property (@(posedge clk) !rst_n |=> !redirect_valid)
        else begin
            failures++;
            $error("redirect_valid high during or right after reset");
        end

    // Two-cycle pulse needs two flow-change strobes in a row
    redirect_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        (redirect_valid && $past(redirect_valid)) |-> ($past(is_flow, 1) && $past(is_flow, 2)))
        else begin
            failures++;
            $error("redirect_valid held without back-to-back ECALL or MRET");
        end

    x0_zero: assert property (@(posedge clk) (dbg_gpr_addr == '0) |-> (dbg_gpr_data == '0))
        else begin
            failures++;
            $error("debug read of x0 is not zero");
        end

endmodule

bind regstate_top regstate_checker u_checker (
    .clk            (clk),
    .rst_n          (rst_n),
    .commit_valid   (commit_valid),
    .commit_op      (commit_op),
    .dbg_gpr_addr   (dbg_gpr_addr),
    .dbg_gpr_data   (dbg_gpr_data),
    .redirect_valid (redirect_valid)
);

/* src/regstate_top.sv */
`timescale 1ns/1ps
`include "core_cfg.svh"

module regstate_top (
    input  logic                     clk,
    input  logic                     rst_n,

    input  logic                     commit_valid,
    input  regstate_pkg::commit_op_e commit_op,
    input  logic [`GPR_ADDR_W-1:0]   commit_rd,
    input  logic [`GPR_ADDR_W-1:0]   commit_rs1,
    input  logic [`CSR_ADDR_W-1:0]   commit_csr,
    input  logic [`XLEN-1:0]         commit_pc,
    input  logic [`XLEN-1:0]         commit_result,

    input  logic [`GPR_ADDR_W-1:0]   dbg_gpr_addr,
    output logic [`XLEN-1:0]         dbg_gpr_data,

    output logic [`XLEN-1:0]         mstatus,
    output logic [`XLEN-1:0]         mtvec,
    output logic [`XLEN-1:0]         mepc,
    output logic [`XLEN-1:0]         mcause,

    output logic                     redirect_valid,
    output logic [`XLEN-1:0]         redirect_pc
);

    gpr_if u_gpr_if ();
    csr_if u_csr_if ();

    gpr_file u_gpr_file (
        .clk      (clk),
        .regs     (u_gpr_if.regfile),
        .dbg_addr (dbg_gpr_addr),
        .dbg_data (dbg_gpr_data)
    );

    csr_file u_csr_file (
        .clk     (clk),
        .rst_n   (rst_n),
        .csrs    (u_csr_if.csrs),
        .mstatus (mstatus),
        .mtvec   (mtvec),
        .mepc    (mepc),
        .mcause  (mcause)
    );

    // Retire path combines both files
    commit_unit u_commit_unit (
        .clk            (clk),
        .rst_n          (rst_n),
        .commit_valid   (commit_valid),
        .commit_op      (commit_op),
        .commit_rd      (commit_rd),
        .commit_rs1     (commit_rs1),
        .commit_csr     (commit_csr),
        .commit_pc      (commit_pc),
        .commit_result  (commit_result),
        .regs           (u_gpr_if.master),
        .csrs           (u_csr_if.master),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

endmodule

/* src/commit_unit.sv */
`timescale 1ns/1ps
`include "core_cfg.svh"

module commit_unit (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     commit_valid,
    input  regstate_pkg::commit_op_e commit_op,
    input  logic [`GPR_ADDR_W-1:0]   commit_rd,
    input  logic [`GPR_ADDR_W-1:0]   commit_rs1,
    input  logic [`CSR_ADDR_W-1:0]   commit_csr,
    input  logic [`XLEN-1:0]         commit_pc,
    input  logic [`XLEN-1:0]         commit_result,
    gpr_if.master                    regs,
    csr_if.master                    csrs,
    output logic                     redirect_valid,
    output logic [`XLEN-1:0]         redirect_pc
);

    import regstate_pkg::*;

    logic is_reg;
    logic is_csrrw;
    logic is_csrrs;
    logic is_csr_op;

    assign is_reg    = commit_valid && (commit_op == OP_REG);
    assign is_csrrw  = commit_valid && (commit_op == OP_CSRRW);
    assign is_csrrs  = commit_valid && (commit_op == OP_CSRRS);
    assign is_csr_op = is_csrrw || is_csrrs;

    // Reads are combinational in the strobe cycle
    assign regs.rs1_addr = commit_rs1;
    assign csrs.csr_addr = commit_csr;

    // rd takes the old CSR value on CSR ops
    assign regs.rd_addr = commit_rd;
    assign regs.rd_data = is_csr_op ? csrs.csr_rdata : commit_result;
    assign regs.rd_wen  = is_reg || is_csr_op;

    assign csrs.csr_wen   = is_csr_op;
    assign csrs.csr_wdata = is_csrrs ? (csrs.csr_rdata | regs.rs1_data) : regs.rs1_data;

    assign csrs.trap_take = commit_valid && (commit_op == OP_ECALL);
    assign csrs.trap_epc  = commit_pc;
    assign csrs.mret_take = commit_valid && (commit_op == OP_MRET);

    // One-cycle redirect pulse after ECALL or MRET
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            redirect_valid <= 1'b0;
        end else begin
            redirect_valid <= csrs.trap_take || csrs.mret_take;
        end
    end

    // Target sampled before the CSR edge updates land
    always_ff @(posedge clk) begin
        if (csrs.trap_take) begin
            redirect_pc <= csrs.mtvec_q;
        end else if (csrs.mret_take) begin
            redirect_pc <= csrs.mepc_q;
        end
    end

endmodule

/* src/csr_file.sv */
`timescale 1ns/1ps
`include "core_cfg.svh"

module csr_file (
    input  logic             clk,
    input  logic             rst_n,
    csr_if.csrs              csrs,
    output logic [`XLEN-1:0] mstatus,
    output logic [`XLEN-1:0] mtvec,
    output logic [`XLEN-1:0] mepc,
    output logic [`XLEN-1:0] mcause
);

    import regstate_pkg::*;

    logic [`XLEN-1:0] mstatus_q;
    logic [`XLEN-1:0] mtvec_q;
    logic [`XLEN-1:0] mepc_q;
    logic [`XLEN-1:0] mcause_q;

    logic wr_mstatus;
    logic wr_mtvec;
    logic wr_mepc;
    logic wr_mcause;

    // Write select, unknown addresses hit nothing
    assign wr_mstatus = csrs.csr_wen && (csrs.csr_addr == CSR_MSTATUS);
    assign wr_mtvec   = csrs.csr_wen && (csrs.csr_addr == CSR_MTVEC);
    assign wr_mepc    = csrs.csr_wen && (csrs.csr_addr == CSR_MEPC);
    assign wr_mcause  = csrs.csr_wen && (csrs.csr_addr == CSR_MCAUSE);

    always_comb begin
        case (csrs.csr_addr)
            CSR_MSTATUS: csrs.csr_rdata = mstatus_q;
            CSR_MTVEC:   csrs.csr_rdata = mtvec_q;
            CSR_MEPC:    csrs.csr_rdata = mepc_q;
            CSR_MCAUSE:  csrs.csr_rdata = mcause_q;
            default:     csrs.csr_rdata = '0;
        endcase
    end

    // Trap entry stacks MIE into MPIE, return pops it back
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mstatus_q <= '0;
        end else if (csrs.trap_take) begin
            mstatus_q[`MSTATUS_MPIE]       <= mstatus_q[`MSTATUS_MIE];
            mstatus_q[`MSTATUS_MIE]        <= 1'b0;
            mstatus_q[`MSTATUS_MPP_LO +: 2] <= 2'b11;
        end else if (csrs.mret_take) begin
            mstatus_q[`MSTATUS_MIE]  <= mstatus_q[`MSTATUS_MPIE];
            mstatus_q[`MSTATUS_MPIE] <= 1'b1;
        end else if (wr_mstatus) begin
            mstatus_q <= csrs.csr_wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mtvec_q <= '0;
        end else if (wr_mtvec) begin
            mtvec_q <= csrs.csr_wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mepc_q <= '0;
        end else if (csrs.trap_take) begin
            mepc_q <= csrs.trap_epc;
        end else if (wr_mepc) begin
            mepc_q <= csrs.csr_wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mcause_q <= '0;
        end else if (csrs.trap_take) begin
            mcause_q <= `XLEN'(`CAUSE_ECALL_M);
        end else if (wr_mcause) begin
            mcause_q <= csrs.csr_wdata;
        end
    end

    assign csrs.mtvec_q = mtvec_q;
    assign csrs.mepc_q  = mepc_q;

    assign mstatus = mstatus_q;
    assign mtvec   = mtvec_q;
    assign mepc    = mepc_q;
    assign mcause  = mcause_q;

endmodule

/* src/gpr_file.sv */
`timescale 1ns/1ps
`include "core_cfg.svh"

module gpr_file (
    input  logic                   clk,
    gpr_if.regfile                 regs,
    input  logic [`GPR_ADDR_W-1:0] dbg_addr,
    output logic [`XLEN-1:0]       dbg_data
);

    logic [`XLEN-1:0] rf [`GPR_COUNT];

    // x0 is never stored
    always_ff @(posedge clk) begin
        if (regs.rd_wen && (regs.rd_addr != '0)) begin
            rf[regs.rd_addr] <= regs.rd_data;
        end
    end

    // Asynchronous reads, index 0 forced to zero
    assign regs.rs1_data = (regs.rs1_addr == '0) ? '0 : rf[regs.rs1_addr];
    assign dbg_data      = (dbg_addr == '0) ? '0 : rf[dbg_addr];

endmodule

/* src/csr_if.sv */
`timescale 1ns/1ps
`include "core_cfg.svh"

interface csr_if;

    logic [`CSR_ADDR_W-1:0] csr_addr;
    logic [`XLEN-1:0]       csr_rdata;
    logic                   csr_wen;
    logic [`XLEN-1:0]       csr_wdata;
    logic                   trap_take;
    logic [`XLEN-1:0]       trap_epc;
    logic                   mret_take;
    // Live trap vector and return address for redirects
    logic [`XLEN-1:0]       mtvec_q;
    logic [`XLEN-1:0]       mepc_q;

    modport master (
        output csr_addr,
        input  csr_rdata,
        output csr_wen,
        output csr_wdata,
        output trap_take,
        output trap_epc,
        output mret_take,
        input  mtvec_q,
        input  mepc_q
    );

    modport csrs (
        input  csr_addr,
        output csr_rdata,
        input  csr_wen,
        input  csr_wdata,
        input  trap_take,
        input  trap_epc,
        input  mret_take,
        output mtvec_q,
        output mepc_q
    );

endinterface

/* src/gpr_if.sv */
`timescale 1ns/1ps
`include "core_cfg.svh"

interface gpr_if;

    logic [`GPR_ADDR_W-1:0] rs1_addr;
    logic [`XLEN-1:0]       rs1_data;
    logic [`GPR_ADDR_W-1:0] rd_addr;
    logic [`XLEN-1:0]       rd_data;
    logic                   rd_wen;

    modport master (
        output rs1_addr,
        input  rs1_data,
        output rd_addr,
        output rd_data,
        output rd_wen
    );

    modport regfile (
        input  rs1_addr,
        output rs1_data,
        input  rd_addr,
        input  rd_data,
        input  rd_wen
    );

endinterface

/* src/regstate_pkg.sv */
`include "core_cfg.svh"

package regstate_pkg;

    // Retiring instruction class, as delivered by execute
    typedef enum logic [2:0] {
        OP_NONE  = 3'd0,
        OP_REG   = 3'd1,
        OP_CSRRW = 3'd2,
        OP_CSRRS = 3'd3,
        OP_ECALL = 3'd4,
        OP_MRET  = 3'd5
    } commit_op_e;

    // Implemented machine CSRs, anything else decodes as absent
    typedef enum logic [`CSR_ADDR_W-1:0] {
        CSR_MSTATUS = 12'h300,
        CSR_MTVEC   = 12'h305,
        CSR_MEPC    = 12'h341,
        CSR_MCAUSE  = 12'h342
    } csr_addr_e;

endpackage

/* src/core_cfg.svh */
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

// Datapath and register file geometry
`define XLEN        32
`define GPR_ADDR_W  5
`define GPR_COUNT   32
`define CSR_ADDR_W  12

// Machine-mode environment call from M
`define CAUSE_ECALL_M  11

// mstatus field positions, MPP is two bits wide
`define MSTATUS_MIE     3
`define MSTATUS_MPIE    7
`define MSTATUS_MPP_LO  11

`endif
